//--- rtl/pad_control_cfg.svh
// sizing macros for the pad multiplexer and its packages
`ifndef PAD_CONTROL_CFG_SVH
`define PAD_CONTROL_CFG_SVH

// pads in the frame
// each pad also owns the gpio bit with the same index
`define PAD_NUM 22

// pad configuration word (drive strength, pulls)
`define PAD_CFG_W 6

// spi master data lines and chip selects
`define SPI_LINES 4
`define SPI_CSN 2

// camera parallel data bus
`define CAM_DATA_W 8

// width of each timer output group
`define TIMER_W 4

`endif

//--- rtl/pad_map_pkg.sv
// pad positions and alternate-function selects of the pad multiplexer
`include "pad_control_cfg.svh"

package pad_map_pkg;

   // alternate function of one pad, 2 bits of the pad control register
   typedef enum logic [1:0] {
      ALT_PERIPH   = 2'd0,
      ALT_GPIO     = 2'd1,
      ALT_SECOND   = 2'd2,
      ALT_RESERVED = 2'd3
   } pad_alt_e;

   // position of each pad in the frame
   typedef enum logic [$clog2(`PAD_NUM)-1:0] {
      // spi master
      SPIM_SDIO0 = 0,
      SPIM_SDIO1,
      SPIM_SDIO2,
      SPIM_SDIO3,
      SPIM_CSN0,
      SPIM_CSN1,
      SPIM_SCK,
      // uart
      UART_RX    = 7,
      UART_TX,
      // camera, contiguous so the timers can walk it in order
      CAM_PCLK   = 9,
      CAM_HSYNC,
      CAM_DATA0,
      CAM_DATA1,
      CAM_DATA2,
      CAM_DATA3,
      CAM_DATA4,
      CAM_DATA5,
      CAM_DATA6,
      CAM_DATA7,
      CAM_VSYNC,
      // i2c port 0
      I2C0_SDA   = 20,
      I2C0_SCL
   } pad_idx_e;

endpackage

//--- rtl/pad_sig_pkg.sv
// per-pad drive and configuration types of the pad multiplexer
`include "pad_control_cfg.svh"

package pad_sig_pkg;

   ////////////////////
   // drive toward one pad

   // out is the level, oe turns the pad driver on
   typedef struct packed {
      logic out;
      logic oe;
   } pad_drive_t;

   ////////////////////
   // pad configuration

   // word handed to the pad cell
   typedef logic [`PAD_CFG_W-1:0] pad_cfg_t;

endpackage

//--- rtl/pad_periph_if.sv
// peripheral side of the pad multiplexer with an output view and an input view
`timescale 1ns/1ps
`include "pad_control_cfg.svh"

interface pad_periph_if;

   // spi master
   logic                                  spi_clk;
   logic [`SPI_CSN-1:0]                   spi_csn;
   logic [`SPI_LINES-1:0]                 spi_oen;
   logic [`SPI_LINES-1:0]                 spi_sdo;
   logic [`SPI_LINES-1:0]                 spi_sdi;

   // uart
   logic                                  uart_tx;
   logic                                  uart_rx;

   // i2c, bit 0 is port 0 and bit 1 is port 1
   logic [1:0]                            i2c_scl_out;
   logic [1:0]                            i2c_scl_oe;
   logic [1:0]                            i2c_sda_out;
   logic [1:0]                            i2c_sda_oe;
   logic [1:0]                            i2c_scl_in;
   logic [1:0]                            i2c_sda_in;

   // camera
   logic                                  cam_pclk;
   logic                                  cam_hsync;
   logic                                  cam_vsync;
   logic [`CAM_DATA_W-1:0]                cam_data;

   // timers
   logic [`TIMER_W-1:0]                   timer1;
   logic [`TIMER_W-1:0]                   timer2;
   logic [`TIMER_W-1:0]                   timer3;

   // gpio
   logic [`PAD_NUM-1:0]                   gpio_out;
   logic [`PAD_NUM-1:0]                   gpio_dir;
   pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0]  gpio_cfg;
   logic [`PAD_NUM-1:0]                   gpio_in;

   // what the output router reads
   modport out_side (
      input spi_clk, spi_csn, spi_oen, spi_sdo, uart_tx,
      input i2c_scl_out, i2c_scl_oe, i2c_sda_out, i2c_sda_oe,
      input timer1, timer2, timer3, gpio_out, gpio_dir, gpio_cfg
   );

   // what the input router drives
   modport in_side (
      output spi_sdi, uart_rx, cam_pclk, cam_hsync, cam_vsync, cam_data,
      output i2c_scl_in, i2c_sda_in, gpio_in
   );

endinterface

//--- rtl/pad_alt_mux.sv
// four-way alternate-function select for one pad, any packed payload
`timescale 1ns/1ps

module pad_alt_mux #(
   parameter type payload_t = pad_sig_pkg::pad_drive_t
) (
   input  pad_map_pkg::pad_alt_e sel_i,
   input  payload_t [3:0]        alt_i,
   output payload_t              pick_o
);

   // alt_i is indexed by the select encoding
   always_comb begin
      case (sel_i)
         pad_map_pkg::ALT_PERIPH: begin
            pick_o = alt_i[pad_map_pkg::ALT_PERIPH];
         end
         pad_map_pkg::ALT_GPIO: begin
            pick_o = alt_i[pad_map_pkg::ALT_GPIO];
         end
         pad_map_pkg::ALT_SECOND: begin
            pick_o = alt_i[pad_map_pkg::ALT_SECOND];
         end
         default: begin
            pick_o = alt_i[pad_map_pkg::ALT_RESERVED];
         end
      endcase
   end

endmodule

//--- rtl/pad_out_router.sv
// output side of the pad mux that builds every pad's alternates and selects one
`timescale 1ns/1ps
`include "pad_control_cfg.svh"

module pad_out_router (
   input  pad_map_pkg::pad_alt_e [`PAD_NUM-1:0] pad_mux_i,
   input  pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] pad_cfg_i,
   pad_periph_if.out_side                       periph,
   output logic                  [`PAD_NUM-1:0] pad_out_o,
   output logic                  [`PAD_NUM-1:0] pad_oe_o,
   output pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] pad_cfg_o
);

   // pclk and hsync, the data pads, then vsync
   localparam int CAM_PADS = `CAM_DATA_W + 3;

   pad_sig_pkg::pad_drive_t [`PAD_NUM-1:0] periph_drv;
   pad_sig_pkg::pad_drive_t [`PAD_NUM-1:0] second_drv;
   pad_sig_pkg::pad_drive_t                i2c1_sda;
   pad_sig_pkg::pad_drive_t                i2c1_scl;
   logic [3*`TIMER_W-1:0]                  timer_bits;

   // timer1 lands on the first camera pads
   assign timer_bits = {periph.timer3, periph.timer2, periph.timer1};

   assign i2c1_sda = '{out: periph.i2c_sda_out[1], oe: periph.i2c_sda_oe[1]};
   assign i2c1_scl = '{out: periph.i2c_scl_out[1], oe: periph.i2c_scl_oe[1]};

   ////////////////////
   // alt 0 sources

   always_comb begin
      // uart rx and the camera pads stay undriven
      periph_drv = '0;
      for (int k = 0; k < `SPI_LINES; k++) begin
         periph_drv[pad_map_pkg::SPIM_SDIO0 + k] = '{
            out: periph.spi_sdo[k],
            oe:  ~periph.spi_oen[k]
         };
      end
      for (int k = 0; k < `SPI_CSN; k++) begin
         periph_drv[pad_map_pkg::SPIM_CSN0 + k] = '{out: periph.spi_csn[k], oe: 1'b1};
      end
      periph_drv[pad_map_pkg::SPIM_SCK] = '{out: periph.spi_clk, oe: 1'b1};
      periph_drv[pad_map_pkg::UART_TX]  = '{out: periph.uart_tx, oe: 1'b1};
      // i2c port 0 is open drain, oe comes from the controller
      periph_drv[pad_map_pkg::I2C0_SDA] = '{
         out: periph.i2c_sda_out[0],
         oe:  periph.i2c_sda_oe[0]
      };
      periph_drv[pad_map_pkg::I2C0_SCL] = '{
         out: periph.i2c_scl_out[0],
         oe:  periph.i2c_scl_oe[0]
      };
   end

   ////////////////////
   // alt 2 sources

   always_comb begin
      second_drv = '0;
      // i2c port 1 has two pad pairs to choose from
      second_drv[pad_map_pkg::SPIM_SDIO2] = i2c1_sda;
      second_drv[pad_map_pkg::UART_RX]    = i2c1_sda;
      second_drv[pad_map_pkg::SPIM_SDIO3] = i2c1_scl;
      second_drv[pad_map_pkg::UART_TX]    = i2c1_scl;
      // timer bits walk the camera pads in pad order
      for (int i = 0; i < CAM_PADS; i++) begin
         second_drv[pad_map_pkg::CAM_PCLK + i] = '{out: timer_bits[i], oe: 1'b1};
      end
   end

   ////////////////////
   // per-pad select

   for (genvar p = 0; p < `PAD_NUM; p++) begin : g_pad
      pad_sig_pkg::pad_drive_t [3:0] drv_alt;
      pad_sig_pkg::pad_cfg_t   [3:0] cfg_alt;
      pad_sig_pkg::pad_drive_t       drv_pick;

      assign drv_alt[pad_map_pkg::ALT_PERIPH]   = periph_drv[p];
      assign drv_alt[pad_map_pkg::ALT_GPIO]     = '{out: periph.gpio_out[p],
                                                    oe:  periph.gpio_dir[p]};
      assign drv_alt[pad_map_pkg::ALT_SECOND]   = second_drv[p];
      assign drv_alt[pad_map_pkg::ALT_RESERVED] = '0;

      // gpio brings its own config word, everything else uses the default
      assign cfg_alt[pad_map_pkg::ALT_PERIPH]   = pad_cfg_i[p];
      assign cfg_alt[pad_map_pkg::ALT_GPIO]     = periph.gpio_cfg[p];
      assign cfg_alt[pad_map_pkg::ALT_SECOND]   = pad_cfg_i[p];
      assign cfg_alt[pad_map_pkg::ALT_RESERVED] = pad_cfg_i[p];

      pad_alt_mux #(
         .payload_t (pad_sig_pkg::pad_drive_t)
      ) u_drv_mux (
         .sel_i  (pad_mux_i[p]),
         .alt_i  (drv_alt),
         .pick_o (drv_pick)
      );

      pad_alt_mux #(
         .payload_t (pad_sig_pkg::pad_cfg_t)
      ) u_cfg_mux (
         .sel_i  (pad_mux_i[p]),
         .alt_i  (cfg_alt),
         .pick_o (pad_cfg_o[p])
      );

      assign pad_out_o[p] = drv_pick.out;
      assign pad_oe_o[p]  = drv_pick.oe;
   end

endmodule

//--- rtl/pad_in_router.sv
// input side of the pad mux that returns pad levels to gpio and the peripherals
`timescale 1ns/1ps
`include "pad_control_cfg.svh"

module pad_in_router (
   input  pad_map_pkg::pad_alt_e [`PAD_NUM-1:0] pad_mux_i,
   input  logic                  [`PAD_NUM-1:0] pad_in_i,
   pad_periph_if.in_side                        periph
);

   logic [`PAD_NUM-1:0] sel_periph;
   logic [`PAD_NUM-1:0] sel_gpio;
   logic [`PAD_NUM-1:0] sel_second;

   // decode each pad's select once
   always_comb begin
      for (int p = 0; p < `PAD_NUM; p++) begin
         sel_periph[p] = (pad_mux_i[p] == pad_map_pkg::ALT_PERIPH);
         sel_gpio[p]   = (pad_mux_i[p] == pad_map_pkg::ALT_GPIO);
         sel_second[p] = (pad_mux_i[p] == pad_map_pkg::ALT_SECOND);
      end
   end

   ////////////////////
   // alt 0 inputs

   // a peripheral sees its pad only while that pad is on alt 0
   always_comb begin
      for (int k = 0; k < `SPI_LINES; k++) begin
         periph.spi_sdi[k] = sel_periph[pad_map_pkg::SPIM_SDIO0 + k] &
                             pad_in_i[pad_map_pkg::SPIM_SDIO0 + k];
      end
      // uart idles high
      periph.uart_rx = sel_periph[pad_map_pkg::UART_RX] ?
                       pad_in_i[pad_map_pkg::UART_RX] : 1'b1;
      periph.cam_pclk  = sel_periph[pad_map_pkg::CAM_PCLK] & pad_in_i[pad_map_pkg::CAM_PCLK];
      periph.cam_hsync = sel_periph[pad_map_pkg::CAM_HSYNC] & pad_in_i[pad_map_pkg::CAM_HSYNC];
      periph.cam_vsync = sel_periph[pad_map_pkg::CAM_VSYNC] & pad_in_i[pad_map_pkg::CAM_VSYNC];
      for (int k = 0; k < `CAM_DATA_W; k++) begin
         periph.cam_data[k] = sel_periph[pad_map_pkg::CAM_DATA0 + k] &
                              pad_in_i[pad_map_pkg::CAM_DATA0 + k];
      end
      // released i2c lines read high
      periph.i2c_sda_in[0] = sel_periph[pad_map_pkg::I2C0_SDA] ?
                             pad_in_i[pad_map_pkg::I2C0_SDA] : 1'b1;
      periph.i2c_scl_in[0] = sel_periph[pad_map_pkg::I2C0_SCL] ?
                             pad_in_i[pad_map_pkg::I2C0_SCL] : 1'b1;
   end

   ////////////////////
   // alt 1 and alt 2 inputs

   assign periph.gpio_in = pad_in_i & sel_gpio;

   // spi data pads win over the uart pads when both carry i2c port 1
   always_comb begin
      if (sel_second[pad_map_pkg::SPIM_SDIO2]) begin
         periph.i2c_sda_in[1] = pad_in_i[pad_map_pkg::SPIM_SDIO2];
      end else if (sel_second[pad_map_pkg::UART_RX]) begin
         periph.i2c_sda_in[1] = pad_in_i[pad_map_pkg::UART_RX];
      end else begin
         periph.i2c_sda_in[1] = 1'b1;
      end
      if (sel_second[pad_map_pkg::SPIM_SDIO3]) begin
         periph.i2c_scl_in[1] = pad_in_i[pad_map_pkg::SPIM_SDIO3];
      end else if (sel_second[pad_map_pkg::UART_TX]) begin
         periph.i2c_scl_in[1] = pad_in_i[pad_map_pkg::UART_TX];
      end else begin
         periph.i2c_scl_in[1] = 1'b1;
      end
   end

endmodule

//--- rtl/pad_control.sv
// pad multiplexer top level connecting peripherals, gpio and the pad frame
`timescale 1ns/1ps
`include "pad_control_cfg.svh"

module pad_control (
   // pad control register
   input  pad_map_pkg::pad_alt_e [`PAD_NUM-1:0] pad_mux_i,
   input  pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] pad_cfg_i,
   output pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] pad_cfg_o,
   // gpio
   input  logic                  [`PAD_NUM-1:0] gpio_out_i,
   input  logic                  [`PAD_NUM-1:0] gpio_dir_i,
   input  pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] gpio_cfg_i,
   output logic                  [`PAD_NUM-1:0] gpio_in_o,
   // spi master
   input  logic                                 spi_clk_i,
   input  logic                  [`SPI_CSN-1:0] spi_csn_i,
   input  logic                [`SPI_LINES-1:0] spi_oen_i,
   input  logic                [`SPI_LINES-1:0] spi_sdo_i,
   output logic                [`SPI_LINES-1:0] spi_sdi_o,
   // uart
   input  logic                                 uart_tx_i,
   output logic                                 uart_rx_o,
   // i2c ports 0 and 1
   input  logic                           [1:0] i2c_scl_out_i,
   input  logic                           [1:0] i2c_scl_oe_i,
   input  logic                           [1:0] i2c_sda_out_i,
   input  logic                           [1:0] i2c_sda_oe_i,
   output logic                           [1:0] i2c_scl_in_o,
   output logic                           [1:0] i2c_sda_in_o,
   // camera
   output logic                                 cam_pclk_o,
   output logic                                 cam_hsync_o,
   output logic                                 cam_vsync_o,
   output logic               [`CAM_DATA_W-1:0] cam_data_o,
   // timers
   input  logic                  [`TIMER_W-1:0] timer1_i,
   input  logic                  [`TIMER_W-1:0] timer2_i,
   input  logic                  [`TIMER_W-1:0] timer3_i,
   // pad frame
   output logic                  [`PAD_NUM-1:0] pad_out_o,
   output logic                  [`PAD_NUM-1:0] pad_oe_o,
   input  logic                  [`PAD_NUM-1:0] pad_in_i
);

   pad_periph_if u_periph ();

   ////////////////////
   // peripheral outputs into the bundle

   assign u_periph.spi_clk     = spi_clk_i;
   assign u_periph.spi_csn     = spi_csn_i;
   assign u_periph.spi_oen     = spi_oen_i;
   assign u_periph.spi_sdo     = spi_sdo_i;
   assign u_periph.uart_tx     = uart_tx_i;
   assign u_periph.i2c_scl_out = i2c_scl_out_i;
   assign u_periph.i2c_scl_oe  = i2c_scl_oe_i;
   assign u_periph.i2c_sda_out = i2c_sda_out_i;
   assign u_periph.i2c_sda_oe  = i2c_sda_oe_i;
   assign u_periph.timer1      = timer1_i;
   assign u_periph.timer2      = timer2_i;
   assign u_periph.timer3      = timer3_i;
   assign u_periph.gpio_out    = gpio_out_i;
   assign u_periph.gpio_dir    = gpio_dir_i;
   assign u_periph.gpio_cfg    = gpio_cfg_i;

   ////////////////////
   // peripheral inputs back out

   assign spi_sdi_o    = u_periph.spi_sdi;
   assign uart_rx_o    = u_periph.uart_rx;
   assign i2c_scl_in_o = u_periph.i2c_scl_in;
   assign i2c_sda_in_o = u_periph.i2c_sda_in;
   assign cam_pclk_o   = u_periph.cam_pclk;
   assign cam_hsync_o  = u_periph.cam_hsync;
   assign cam_vsync_o  = u_periph.cam_vsync;
   assign cam_data_o   = u_periph.cam_data;
   assign gpio_in_o    = u_periph.gpio_in;

   pad_out_router u_out_router (
      .pad_mux_i (pad_mux_i),
      .pad_cfg_i (pad_cfg_i),
      .periph    (u_periph.out_side),
      .pad_out_o (pad_out_o),
      .pad_oe_o  (pad_oe_o),
      .pad_cfg_o (pad_cfg_o)
   );

   pad_in_router u_in_router (
      .pad_mux_i (pad_mux_i),
      .pad_in_i  (pad_in_i),
      .periph    (u_periph.in_side)
   );

endmodule

//--- tests/tb_pad_control.sv
// directed testbench for the pad multiplexer with a table-driven reference model
`timescale 1ns/1ps
`include "pad_control_cfg.svh"

module tb_pad_control;

   localparam int NUM_TESTS   = 6;
   localparam int STEPS       = 8;
   localparam int CLK_NS      = 40;
   localparam int WATCHDOG_NS = (NUM_TESTS * STEPS + 8 + 4) * CLK_NS;
   localparam int PADS_W      = 2 * `PAD_NUM + `PAD_NUM * `PAD_CFG_W;
   localparam int INS_W       = `PAD_NUM + `SPI_LINES + 8 + `CAM_DATA_W;

   logic clk;
   logic arst_n;

   // names follow the DUT ports so the instance connects by name
   pad_map_pkg::pad_alt_e [`PAD_NUM-1:0] pad_mux_i;
   pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] pad_cfg_i, gpio_cfg_i, pad_cfg_o;
   logic [`PAD_NUM-1:0]    gpio_out_i, gpio_dir_i, gpio_in_o, pad_out_o, pad_oe_o, pad_in_i;
   logic                   spi_clk_i, uart_tx_i, uart_rx_o;
   logic [`SPI_CSN-1:0]    spi_csn_i;
   logic [`SPI_LINES-1:0]  spi_oen_i, spi_sdo_i, spi_sdi_o;
   logic [1:0]             i2c_scl_out_i, i2c_scl_oe_i, i2c_sda_out_i, i2c_sda_oe_i;
   logic [1:0]             i2c_scl_in_o, i2c_sda_in_o;
   logic                   cam_pclk_o, cam_hsync_o, cam_vsync_o;
   logic [`CAM_DATA_W-1:0] cam_data_o;
   logic [`TIMER_W-1:0]    timer1_i, timer2_i, timer3_i;

   logic [PADS_W-1:0] exp_pads;
   logic [PADS_W-1:0] act_pads;
   logic [INS_W-1:0]  exp_ins;
   logic [INS_W-1:0]  act_ins;
   logic [31:0]       lcg_state = 32'd19086;
   int                errors = 0;
   int                checks = 0;
   int                tests_run = 0;

   pad_control u_pad_control (.*);

   assign act_pads = {pad_out_o, pad_oe_o, pad_cfg_o};
   assign act_ins  = {gpio_in_o, spi_sdi_o, uart_rx_o, i2c_scl_in_o, i2c_sda_in_o,
                      cam_pclk_o, cam_hsync_o, cam_vsync_o, cam_data_o};

   initial clk = 1'b0;
   always #(CLK_NS / 2) clk = ~clk;

   // two lcg steps, only the upper halves carry well mixed bits
   function automatic logic [31:0] next_rand();
      logic [15:0] hi;
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      hi = lcg_state[31:16];
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {hi, lcg_state[31:16]};
   endfunction

   ////////////////////
   // reference model

   // pad numbers follow the pad map with spi data on 0-3, uart on 7/8, camera on 9-19
   // and i2c0 on 20/21
   task automatic build_expected();
      logic [`PAD_NUM-1:0]                  e_out;
      logic [`PAD_NUM-1:0]                  e_oe;
      pad_sig_pkg::pad_cfg_t [`PAD_NUM-1:0] e_cfg;
      logic [`PAD_NUM-1:0]                  is_p;
      logic [`PAD_NUM-1:0]                  is_g;
      logic [`PAD_NUM-1:0]                  is_s;
      logic [3*`TIMER_W-1:0]                tmr;
      tmr = {timer3_i, timer2_i, timer1_i};
      for (int p = 0; p < `PAD_NUM; p++) begin
         is_p[p] = (pad_mux_i[p] == pad_map_pkg::ALT_PERIPH);
         is_g[p] = (pad_mux_i[p] == pad_map_pkg::ALT_GPIO);
         is_s[p] = (pad_mux_i[p] == pad_map_pkg::ALT_SECOND);
         e_cfg[p] = is_g[p] ? gpio_cfg_i[p] : pad_cfg_i[p];
         {e_out[p], e_oe[p]} = 2'b00;
         if (is_g[p]) begin
            {e_out[p], e_oe[p]} = {gpio_out_i[p], gpio_dir_i[p]};
         end else if (is_p[p]) begin
            if (p < 4) {e_out[p], e_oe[p]} = {spi_sdo_i[p], ~spi_oen_i[p]};
            else if (p < 6) {e_out[p], e_oe[p]} = {spi_csn_i[p-4], 1'b1};
            else if (p == 6) {e_out[p], e_oe[p]} = {spi_clk_i, 1'b1};
            else if (p == 8) {e_out[p], e_oe[p]} = {uart_tx_i, 1'b1};
            else if (p == 20) {e_out[p], e_oe[p]} = {i2c_sda_out_i[0], i2c_sda_oe_i[0]};
            else if (p == 21) {e_out[p], e_oe[p]} = {i2c_scl_out_i[0], i2c_scl_oe_i[0]};
         end else if (is_s[p]) begin
            if (p == 2 || p == 7) {e_out[p], e_oe[p]} = {i2c_sda_out_i[1], i2c_sda_oe_i[1]};
            else if (p == 3 || p == 8) {e_out[p], e_oe[p]} = {i2c_scl_out_i[1], i2c_scl_oe_i[1]};
            else if (p >= 9 && p <= 19) {e_out[p], e_oe[p]} = {tmr[p-9], 1'b1};
         end
      end
      exp_pads = {e_out, e_oe, e_cfg};
      // uart and i2c idle high, spi and camera idle low
      exp_ins = {is_g & pad_in_i, is_p[3:0] & pad_in_i[3:0],
                 is_p[7] ? pad_in_i[7] : 1'b1,
                 is_s[3] ? pad_in_i[3] : (is_s[8] ? pad_in_i[8] : 1'b1),
                 is_p[21] ? pad_in_i[21] : 1'b1,
                 is_s[2] ? pad_in_i[2] : (is_s[7] ? pad_in_i[7] : 1'b1),
                 is_p[20] ? pad_in_i[20] : 1'b1,
                 is_p[9] & pad_in_i[9], is_p[10] & pad_in_i[10], is_p[19] & pad_in_i[19],
                 is_p[18:11] & pad_in_i[18:11]};
   endtask

   ////////////////////
   // stimulus and checks

   task automatic set_all_selects(input pad_map_pkg::pad_alt_e alt);
      for (int p = 0; p < `PAD_NUM; p++) pad_mux_i[p] = alt;
   endtask

   // new random peripheral and pad values shortly after the rising edge
   task automatic drive_step();
      logic [31:0] r;
      @(posedge clk);
      #2;
      gpio_out_i = next_rand();
      gpio_dir_i = next_rand();
      pad_in_i = next_rand();
      r = next_rand();
      {timer3_i, timer2_i, timer1_i, i2c_sda_oe_i, i2c_sda_out_i} = r[31:16];
      {i2c_scl_oe_i, i2c_scl_out_i, uart_tx_i, spi_sdo_i, spi_oen_i, spi_csn_i} = r[15:1];
      spi_clk_i = r[0];
      for (int p = 0; p < `PAD_NUM; p++) begin
         r = next_rand();
         pad_cfg_i[p] = r[`PAD_CFG_W-1:0];
         gpio_cfg_i[p] = r[8 +: `PAD_CFG_W];
      end
   endtask

   task automatic check_step(input string name);
      @(negedge clk);
      build_expected();
      checks += 2;
      assert (act_pads == exp_pads) else begin
         $display("Fail %s pad side expected %h actual %h", name, exp_pads, act_pads);
         errors++;
      end
      assert (act_ins == exp_ins) else begin
         $display("Fail %s input side expected %h actual %h", name, exp_ins, act_ins);
         errors++;
      end
   endtask

   task automatic run_test(input string name, input int kind);
      int          base;
      logic [31:0] r;
      base = errors;
      for (int s = 0; s < STEPS; s++) begin
         drive_step();
         set_all_selects(pad_map_pkg::ALT_PERIPH);
         case (kind)
            1: set_all_selects(pad_map_pkg::ALT_GPIO);
            2: begin
               // spi pair alone, uart pair alone, then both pairs
               if (s % 3 != 1) begin
                  pad_mux_i[pad_map_pkg::SPIM_SDIO2] = pad_map_pkg::ALT_SECOND;
                  pad_mux_i[pad_map_pkg::SPIM_SDIO3] = pad_map_pkg::ALT_SECOND;
               end
               if (s % 3 != 0) begin
                  pad_mux_i[pad_map_pkg::UART_RX] = pad_map_pkg::ALT_SECOND;
                  pad_mux_i[pad_map_pkg::UART_TX] = pad_map_pkg::ALT_SECOND;
               end
               // opposite levels on the two source pads expose the priority
               pad_in_i[pad_map_pkg::UART_RX] = ~pad_in_i[pad_map_pkg::SPIM_SDIO2];
               pad_in_i[pad_map_pkg::UART_TX] = ~pad_in_i[pad_map_pkg::SPIM_SDIO3];
            end
            3: begin
               for (int p = pad_map_pkg::CAM_PCLK; p <= pad_map_pkg::CAM_VSYNC; p++) begin
                  pad_mux_i[p] = pad_map_pkg::ALT_SECOND;
               end
            end
            4: set_all_selects(pad_map_pkg::ALT_RESERVED);
            5: begin
               for (int p = 0; p < `PAD_NUM; p++) begin
                  r = next_rand();
                  pad_mux_i[p] = pad_map_pkg::pad_alt_e'(r[17:16]);
               end
            end
            default: ;
         endcase
         check_step(name);
      end
      tests_run++;
      $display("%s done, %0d mismatches", name, errors - base);
   endtask

   ////////////////////
   // sequence and watchdog

   // reset holds off the first test for eight cycles
   initial begin
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      arst_n = 1'b1;
   end

   initial begin
      set_all_selects(pad_map_pkg::ALT_RESERVED);
      {pad_cfg_i, gpio_cfg_i, gpio_out_i, gpio_dir_i, pad_in_i} = '0;
      {spi_clk_i, spi_csn_i, spi_oen_i, spi_sdo_i, uart_tx_i} = '0;
      {i2c_scl_out_i, i2c_scl_oe_i, i2c_sda_out_i, i2c_sda_oe_i} = '0;
      {timer1_i, timer2_i, timer3_i} = '0;
      @(posedge arst_n);
      run_test("all_periph", 0);
      run_test("all_gpio", 1);
      run_test("i2c1_second", 2);
      run_test("cam_timers", 3);
      run_test("all_reserved", 4);
      run_test("random_mix", 5);
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
      $display("test failed");
      $finish;
   end

endmodule

//--- build.f
+incdir+rtl
rtl/pad_map_pkg.sv
rtl/pad_sig_pkg.sv
rtl/pad_periph_if.sv
rtl/pad_alt_mux.sv
rtl/pad_out_router.sv
rtl/pad_in_router.sv
rtl/pad_control.sv
tests/tb_pad_control.sv

//--- Bender.yml
package:
  name: pad_control

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pad_map_pkg.sv
      - rtl/pad_sig_pkg.sv
      - rtl/pad_periph_if.sv
      - rtl/pad_alt_mux.sv
      - rtl/pad_out_router.sv
      - rtl/pad_in_router.sv
      - rtl/pad_control.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_pad_control.sv
